// ==== src/ps2_pkg.sv ====
package ps2_pkg;

    // One byte as it comes off the PS/2 data line
    typedef logic [7:0] scan_byte_t;

    // Extend flag sits above the scan byte, so extended keys land in the upper half
    typedef logic [8:0] key_code_t;
    typedef logic [511:0] key_map_t;

    typedef logic [15:0] count_t;

    typedef logic [1:0] reg_addr_t;
    typedef logic [15:0] reg_data_t;

    localparam scan_byte_t SCAN_BAT_OK = 8'hAA;
    localparam scan_byte_t SCAN_EXTEND = 8'hE0;
    localparam scan_byte_t SCAN_BREAK = 8'hF0;

    typedef enum logic [1:0] {
        wait_bat,
        idle,
        done
    } dec_state_t;

    // Control register holds enable in bit 0, skip_bat in bit 1, clear_map in bit 2
    localparam reg_addr_t REG_CTRL = 2'd0;
    localparam reg_addr_t REG_ERR_COUNT = 2'd1;
    localparam reg_addr_t REG_EVENT_COUNT = 2'd2;
    localparam reg_addr_t REG_DROP_COUNT = 2'd3;

endpackage

// ==== src/ps2_rx.sv ====
`timescale 1ns/1ps

module ps2_rx import ps2_pkg::*; #(
    parameter int RX_TIMEOUT = 2000
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       ps2_clk,
    input  logic       ps2_data,
    output scan_byte_t rx_byte,
    output logic       rx_valid,
    output logic       rx_err
);

    localparam int TIMER_W = $clog2(RX_TIMEOUT + 1);

    logic               clk_meta;
    logic               clk_sync;
    logic               clk_prev;
    logic               data_meta;
    logic               data_sync;
    logic               clk_fall;
    logic [3:0]         bit_cnt;
    logic [9:0]         shift;
    logic [10:0]        frame;
    logic               frame_ok;
    logic [TIMER_W-1:0] timer;
    logic               timed_out;

    // Both lines idle high, so the synchronizers come out of reset at 1
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            clk_meta  <= 1'b1;
            clk_sync  <= 1'b1;
            clk_prev  <= 1'b1;
            data_meta <= 1'b1;
            data_sync <= 1'b1;
        end else begin
            clk_meta  <= ps2_clk;
            clk_sync  <= clk_meta;
            clk_prev  <= clk_sync;
            data_meta <= ps2_data;
            data_sync <= data_meta;
        end
    end

    assign clk_fall = clk_prev & ~clk_sync;

    // Bits arrive LSB first behind the start bit, with the stop bit still on the line
    assign frame = {data_sync, shift};

    // Start low, odd parity over data and parity bit, stop high
    assign frame_ok = ~frame[0] & (^frame[9:1]) & frame[10];

    assign timed_out = (bit_cnt != 4'd0) && (timer == TIMER_W'(RX_TIMEOUT));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bit_cnt  <= '0;
            timer    <= '0;
            rx_valid <= 1'b0;
            rx_err   <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            rx_err   <= 1'b0;
            if (clk_fall) begin
                timer <= '0;
                if (bit_cnt == 4'd10) begin
                    bit_cnt  <= '0;
                    rx_valid <= frame_ok;
                    rx_err   <= ~frame_ok;
                end else begin
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end else if (timed_out) begin
                // The keyboard stopped clocking mid-frame, so drop what we have
                bit_cnt <= '0;
                timer   <= '0;
                rx_err  <= 1'b1;
            end else if (bit_cnt != 4'd0) begin
                timer <= timer + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (clk_fall) begin
            shift <= {data_sync, shift[9:1]};
        end
        if (clk_fall && bit_cnt == 4'd10) begin
            rx_byte <= frame[8:1];
        end
    end

    a_rx_strobes_exclusive: assert property (
        @(posedge clk) disable iff (rst) !(rx_valid && rx_err)
    ) else $error("ps2_rx: rx_valid and rx_err high in the same cycle");

endmodule

// ==== src/scan_decoder.sv ====
`timescale 1ns/1ps

module scan_decoder import ps2_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  scan_byte_t rx_byte,
    input  logic       rx_valid,
    input  logic       rx_err,
    input  logic       enable,
    input  logic       skip_bat,
    input  logic       clear_map,
    input  logic       full,
    output key_map_t   key_down,
    output logic       push,
    output key_code_t  push_code,
    output logic       push_break,
    output logic       event_seen,
    output logic       event_dropped,
    output logic       frame_err
);

    dec_state_t state;
    logic       extend_flag;
    logic       break_flag;
    logic       byte_in;
    logic       is_prefix;
    key_code_t  code;

    // A disabled decoder behaves as if no byte had arrived
    assign byte_in = rx_valid & enable;

    assign is_prefix = (rx_byte == SCAN_EXTEND) || (rx_byte == SCAN_BREAK);
    assign code = {extend_flag, rx_byte};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state         <= wait_bat;
            extend_flag   <= 1'b0;
            break_flag    <= 1'b0;
            key_down      <= '0;
            push          <= 1'b0;
            event_seen    <= 1'b0;
            event_dropped <= 1'b0;
            frame_err     <= 1'b0;
        end else begin
            push          <= 1'b0;
            event_seen    <= 1'b0;
            event_dropped <= 1'b0;
            frame_err     <= rx_err;

            case (state)
                wait_bat: begin
                    // Nothing is decoded until the keyboard reports a passed self-test
                    if (skip_bat || (byte_in && rx_byte == SCAN_BAT_OK)) begin
                        state <= idle;
                    end
                end
                idle: begin
                    if (byte_in) begin
                        if (rx_byte == SCAN_EXTEND) begin
                            extend_flag <= 1'b1;
                        end else if (rx_byte == SCAN_BREAK) begin
                            break_flag <= 1'b1;
                        end else begin
                            key_down[code] <= ~break_flag;
                            event_seen     <= 1'b1;
                            push           <= ~full;
                            event_dropped  <= full;
                            state          <= done;
                        end
                    end
                end
                done: begin
                    extend_flag <= 1'b0;
                    break_flag  <= 1'b0;
                    state       <= idle;
                end
                default: begin
                    state <= wait_bat;
                end
            endcase

            // A broken frame may have been the code that belonged to a pending prefix
            if (rx_err) begin
                extend_flag <= 1'b0;
                break_flag  <= 1'b0;
            end

            if (clear_map) begin
                key_down    <= '0;
                extend_flag <= 1'b0;
                break_flag  <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (byte_in && state == idle && !is_prefix) begin
            push_code  <= code;
            push_break <= break_flag;
        end
    end

    a_no_push_when_full: assert property (
        @(posedge clk) disable iff (rst) push |-> !full
    ) else $error("scan_decoder: event pushed into a full FIFO");

endmodule

// ==== src/kbd_regs.sv ====
`timescale 1ns/1ps

module kbd_regs import ps2_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      reg_wr,
    input  logic      reg_rd,
    input  reg_addr_t reg_addr,
    input  reg_data_t reg_wdata,
    input  logic      event_seen,
    input  logic      event_dropped,
    input  logic      frame_err,
    output reg_data_t reg_rdata,
    output logic      enable,
    output logic      skip_bat,
    output logic      clear_map
);

    count_t err_count;
    count_t event_count;
    count_t drop_count;
    logic   wr_ctrl;
    logic   wr_err;
    logic   wr_event;
    logic   wr_drop;

    // Counters stick at their top value instead of wrapping
    function automatic count_t sat_inc(input count_t value);
        return (value == '1) ? value : value + count_t'(1);
    endfunction

    assign wr_ctrl = reg_wr && (reg_addr == REG_CTRL);
    assign wr_err = reg_wr && (reg_addr == REG_ERR_COUNT);
    assign wr_event = reg_wr && (reg_addr == REG_EVENT_COUNT);
    assign wr_drop = reg_wr && (reg_addr == REG_DROP_COUNT);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            enable    <= 1'b1;
            skip_bat  <= 1'b0;
            clear_map <= 1'b0;
        end else begin
            clear_map <= wr_ctrl && reg_wdata[2];
            if (wr_ctrl) begin
                enable   <= reg_wdata[0];
                skip_bat <= reg_wdata[1];
            end
        end
    end

    // A write to a counter clears it, and wins over an increment in the same cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            err_count   <= '0;
            event_count <= '0;
            drop_count  <= '0;
        end else begin
            if (wr_err) begin
                err_count <= '0;
            end else if (frame_err) begin
                err_count <= sat_inc(err_count);
            end
            if (wr_event) begin
                event_count <= '0;
            end else if (event_seen) begin
                event_count <= sat_inc(event_count);
            end
            if (wr_drop) begin
                drop_count <= '0;
            end else if (event_dropped) begin
                drop_count <= sat_inc(drop_count);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reg_rd) begin
            case (reg_addr)
                REG_CTRL:        reg_rdata <= reg_data_t'({skip_bat, enable});
                REG_ERR_COUNT:   reg_rdata <= reg_data_t'(err_count);
                REG_EVENT_COUNT: reg_rdata <= reg_data_t'(event_count);
                default:         reg_rdata <= reg_data_t'(drop_count);
            endcase
        end
    end

endmodule

// ==== src/key_event_fifo.sv ====
`timescale 1ns/1ps

module key_event_fifo import ps2_pkg::*; #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      push,
    input  key_code_t push_code,
    input  logic      push_break,
    input  logic      key_event_ready,
    output logic      full,
    output logic      key_event_valid,
    output key_code_t key_event_code,
    output logic      key_event_break
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int ENTRY_W = $bits(key_code_t) + 1;

    logic [ENTRY_W-1:0] mem [FIFO_DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [PTR_W:0]     count;
    logic               wr_en;
    logic               rd_en;

    assign full = (count == (PTR_W + 1)'(FIFO_DEPTH));
    assign key_event_valid = (count != '0);
    assign wr_en = push & ~full;
    assign rd_en = key_event_valid & key_event_ready;

    // Head entry sits on the outputs as soon as it is written
    assign {key_event_break, key_event_code} = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= {push_break, push_code};
        end
    end

    // Depth is a power of two, so the pointers wrap on their own
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_hold_under_backpressure: assert property (
        @(posedge clk) disable iff (rst)
        key_event_valid && !key_event_ready |=> key_event_valid && $stable(key_event_code)
    ) else $error("key_event_fifo: output event changed before it was taken");

endmodule

// ==== src/kbd_top.sv ====
`timescale 1ns/1ps

module kbd_top import ps2_pkg::*; #(
    parameter int RX_TIMEOUT = 2000,
    parameter int FIFO_DEPTH = 4
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      ps2_clk,
    input  logic      ps2_data,
    input  logic      reg_wr,
    input  logic      reg_rd,
    input  reg_addr_t reg_addr,
    input  reg_data_t reg_wdata,
    input  logic      key_event_ready,
    output reg_data_t reg_rdata,
    output key_map_t  key_down,
    output logic      key_event_valid,
    output key_code_t key_event_code,
    output logic      key_event_break
);

    scan_byte_t rx_byte;
    logic       rx_valid;
    logic       rx_err;
    logic       enable;
    logic       skip_bat;
    logic       clear_map;
    logic       push;
    key_code_t  push_code;
    logic       push_break;
    logic       full;
    logic       event_seen;
    logic       event_dropped;
    logic       frame_err;

    ps2_rx #(
        .RX_TIMEOUT(RX_TIMEOUT)
    ) u_rx (
        .clk      (clk),
        .rst      (rst),
        .ps2_clk  (ps2_clk),
        .ps2_data (ps2_data),
        .rx_byte  (rx_byte),
        .rx_valid (rx_valid),
        .rx_err   (rx_err)
    );

    scan_decoder u_decoder (
        .clk           (clk),
        .rst           (rst),
        .rx_byte       (rx_byte),
        .rx_valid      (rx_valid),
        .rx_err        (rx_err),
        .enable        (enable),
        .skip_bat      (skip_bat),
        .clear_map     (clear_map),
        .full          (full),
        .key_down      (key_down),
        .push          (push),
        .push_code     (push_code),
        .push_break    (push_break),
        .event_seen    (event_seen),
        .event_dropped (event_dropped),
        .frame_err     (frame_err)
    );

    kbd_regs u_regs (
        .clk           (clk),
        .rst           (rst),
        .reg_wr        (reg_wr),
        .reg_rd        (reg_rd),
        .reg_addr      (reg_addr),
        .reg_wdata     (reg_wdata),
        .event_seen    (event_seen),
        .event_dropped (event_dropped),
        .frame_err     (frame_err),
        .reg_rdata     (reg_rdata),
        .enable        (enable),
        .skip_bat      (skip_bat),
        .clear_map     (clear_map)
    );

    key_event_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) u_fifo (
        .clk             (clk),
        .rst             (rst),
        .push            (push),
        .push_code       (push_code),
        .push_break      (push_break),
        .key_event_ready (key_event_ready),
        .full            (full),
        .key_event_valid (key_event_valid),
        .key_event_code  (key_event_code),
        .key_event_break (key_event_break)
    );

endmodule

// ==== testbench/tb_ps2_device.svh ====
`ifndef TB_PS2_DEVICE_SVH
`define TB_PS2_DEVICE_SVH

// Keyboard side of the PS/2 link. The keyboard only ever pulls a line low,
// the pull-up in the bench brings it back high

// Half a PS/2 bit period, counted in system clocks so edges stay clear of clk
task automatic half_bit_wait();
    repeat (HALF_BIT_CYCLES) @(posedge clk);
    #1;
endtask

// Start bit, eight data bits LSB first, parity, stop bit
function automatic logic [10:0] build_frame(input scan_byte_t data, input logic bad_parity);
    logic parity;
    parity = (~^data) ^ bad_parity;
    return {1'b1, parity, data, 1'b0};
endfunction

// Data changes while the clock is high, the host samples on the falling edge
task automatic shift_out_bits(input logic [10:0] frame, input int n_bits);
    for (int i = 0; i < n_bits; i++) begin
        data_pull_low = ~frame[i];
        half_bit_wait();
        clk_pull_low = 1'b1;
        half_bit_wait();
        clk_pull_low = 1'b0;
    end
    data_pull_low = 1'b0;
    half_bit_wait();
endtask

task automatic send_frame(input scan_byte_t data, input logic bad_parity);
    shift_out_bits(build_frame(data, bad_parity), 11);
endtask

// Keyboard gives up part-way and leaves both lines released
task automatic send_truncated(input scan_byte_t data, input int n_bits);
    shift_out_bits(build_frame(data, 1'b0), n_bits);
endtask

`endif

// ==== testbench/tb_kbd_top.sv ====
`timescale 1ns/1ps

module tb_kbd_top import ps2_pkg::*; ();

    localparam int RX_TIMEOUT = 200;
    localparam int FIFO_DEPTH = 4;
    localparam int BURST_LEN = FIFO_DEPTH + 2;
    localparam int HALF_BIT_CYCLES = 10;
    localparam int SETTLE_CYCLES = 8;
    localparam int EVENT_TIMEOUT = 40;
    localparam int DRAIN_TIMEOUT = 200;
    localparam int ERR_POLL_LIMIT = 300;
    localparam int NUM_ROWS = 17;

    typedef struct packed {
        scan_byte_t data;
        logic       bad_parity;
        logic       has_event;
        key_code_t  code;
        logic       brk;
        logic       down;
    } stim_row_t;

    logic      clk;
    logic      rst;
    logic      clk_pull_low;
    logic      data_pull_low;
    logic      ps2_clk;
    logic      ps2_data;
    logic      reg_wr;
    logic      reg_rd;
    reg_addr_t reg_addr;
    reg_data_t reg_wdata;
    logic      key_event_ready;
    reg_data_t reg_rdata;
    key_map_t  key_down;
    logic      key_event_valid;
    key_code_t key_event_code;
    logic      key_event_break;
    key_map_t  model;
    int        seed = 32'hf22d;

    // Byte, bad parity, event expected, code, break, resulting key_down bit
    stim_row_t stim [NUM_ROWS] = '{
        '{8'h1C, 1'b0, 1'b0, 9'h000, 1'b0, 1'b0},
        '{8'hF0, 1'b0, 1'b0, 9'h000, 1'b0, 1'b0},
        '{8'hAA, 1'b0, 1'b0, 9'h000, 1'b0, 1'b0},
        '{8'h1C, 1'b0, 1'b1, 9'h01C, 1'b0, 1'b1},
        '{8'hE0, 1'b0, 1'b0, 9'h000, 1'b0, 1'b0},
        '{8'h75, 1'b0, 1'b1, 9'h175, 1'b0, 1'b1},
        '{8'hE0, 1'b0, 1'b0, 9'h000, 1'b0, 1'b0},
        '{8'hF0, 1'b0, 1'b0, 9'h000, 1'b0, 1'b0},
        '{8'h75, 1'b0, 1'b1, 9'h175, 1'b1, 1'b0},
        '{8'hF0, 1'b0, 1'b0, 9'h000, 1'b0, 1'b0},
        '{8'h1C, 1'b0, 1'b1, 9'h01C, 1'b1, 1'b0},
        '{8'hE0, 1'b0, 1'b0, 9'h000, 1'b0, 1'b0},
        '{8'h75, 1'b1, 1'b0, 9'h000, 1'b0, 1'b0},
        '{8'h75, 1'b0, 1'b1, 9'h075, 1'b0, 1'b1},
        '{8'hF0, 1'b0, 1'b0, 9'h000, 1'b0, 1'b0},
        '{8'h75, 1'b0, 1'b1, 9'h075, 1'b1, 1'b0},
        '{8'h2B, 1'b0, 1'b1, 9'h02B, 1'b0, 1'b1}
    };

    scan_byte_t burst_codes [BURST_LEN] = '{8'h15, 8'h1D, 8'h24, 8'h2D, 8'h2C, 8'h35};

    // Open-drain lines with a pull-up
    assign ps2_clk = ~clk_pull_low;
    assign ps2_data = ~data_pull_low;

    always #5 clk = ~clk;

    kbd_top #(
        .RX_TIMEOUT(RX_TIMEOUT),
        .FIFO_DEPTH(FIFO_DEPTH)
    ) uut (
        .clk             (clk),
        .rst             (rst),
        .ps2_clk         (ps2_clk),
        .ps2_data        (ps2_data),
        .reg_wr          (reg_wr),
        .reg_rd          (reg_rd),
        .reg_addr        (reg_addr),
        .reg_wdata       (reg_wdata),
        .key_event_ready (key_event_ready),
        .reg_rdata       (reg_rdata),
        .key_down        (key_down),
        .key_event_valid (key_event_valid),
        .key_event_code  (key_event_code),
        .key_event_break (key_event_break)
    );

    `include "tb_ps2_device.svh"

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1, "Simulation stopped after a failure");
    endtask

    task automatic check_value(input string name, input logic [511:0] actual,
                               input logic [511:0] expected);
        if (actual !== expected) begin
            stop_with_failure($sformatf("Error at %0t ns: %s is %0h, expected %0h",
                                        $time, name, actual, expected));
        end
    endtask

    task automatic settle(input int cycles);
        repeat (cycles) @(posedge clk);
        #1;
    endtask

    task automatic apply_reset();
        rst = 1'b1;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
    endtask

    task automatic write_reg(input reg_addr_t addr, input reg_data_t data);
        reg_wr    = 1'b1;
        reg_addr  = addr;
        reg_wdata = data;
        settle(1);
        reg_wr = 1'b0;
    endtask

    // Read data is registered, so it is sampled one cycle after the request
    task automatic read_reg(input reg_addr_t addr, output reg_data_t value);
        reg_rd   = 1'b1;
        reg_addr = addr;
        settle(1);
        reg_rd = 1'b0;
        value  = reg_rdata;
    endtask

    task automatic expect_reg(input reg_addr_t addr, input string name, input int expected);
        reg_data_t value;
        read_reg(addr, value);
        check_value(name, 512'(value), 512'(expected));
    endtask

    task automatic wait_for_event();
        int waited;
        waited = 0;
        while (!key_event_valid) begin
            if (waited >= EVENT_TIMEOUT) begin
                stop_with_failure("Timed out waiting for a key event on the output");
            end
            settle(1);
            waited++;
        end
    endtask

    // Check the head event, accept it, and expect the FIFO to be empty after
    task automatic take_event(input key_code_t code, input logic brk);
        wait_for_event();
        check_value("key_event_code", 512'(key_event_code), 512'(code));
        check_value("key_event_break", 512'(key_event_break), 512'(brk));
        key_event_ready = 1'b1;
        settle(1);
        key_event_ready = 1'b0;
        check_value("key_event_valid", 512'(key_event_valid), 512'(0));
    endtask

    task automatic expect_no_event();
        settle(SETTLE_CYCLES);
        check_value("key_event_valid", 512'(key_event_valid), 512'(0));
        check_value("key_down", key_down, model);
    endtask

    initial begin
        int        expected_events;
        int        expected_errors;
        int        polls;
        int        taken;
        int        waited;
        int        rnd;
        reg_data_t value;

        clk             = 1'b0;
        rst             = 1'b1;
        clk_pull_low    = 1'b0;
        data_pull_low   = 1'b0;
        reg_wr          = 1'b0;
        reg_rd          = 1'b0;
        reg_addr        = '0;
        reg_wdata       = '0;
        key_event_ready = 1'b0;
        model           = '0;
        expected_events = 0;
        expected_errors = 0;

        apply_reset();
        check_value("key_down", key_down, model);
        check_value("key_event_valid", 512'(key_event_valid), 512'(0));
        expect_reg(REG_CTRL, "ctrl", 1);
        expect_reg(REG_ERR_COUNT, "err_count", 0);
        expect_reg(REG_EVENT_COUNT, "event_count", 0);
        expect_reg(REG_DROP_COUNT, "drop_count", 0);

        // Self-test wait, prefixes, breaks and a bad-parity frame
        for (int i = 0; i < NUM_ROWS; i++) begin
            send_frame(stim[i].data, stim[i].bad_parity);
            if (stim[i].has_event) begin
                take_event(stim[i].code, stim[i].brk);
                model[stim[i].code] = stim[i].down;
                check_value("key_down bit", 512'(key_down[stim[i].code]), 512'(stim[i].down));
                expected_events++;
            end else begin
                expect_no_event();
            end
            if (stim[i].bad_parity) begin
                expected_errors++;
            end
            check_value("key_down", key_down, model);
        end
        expect_reg(REG_EVENT_COUNT, "event_count", expected_events);
        expect_reg(REG_ERR_COUNT, "err_count", expected_errors);

        // A frame that stops part-way is dropped once the receiver times out
        send_truncated(8'h33, 5);
        expected_errors++;
        polls = 0;
        read_reg(REG_ERR_COUNT, value);
        while (int'(value) != expected_errors) begin
            if (polls >= ERR_POLL_LIMIT) begin
                stop_with_failure("The error counter never counted the truncated frame");
            end
            read_reg(REG_ERR_COUNT, value);
            polls++;
        end
        expect_no_event();

        // Under back-pressure the FIFO keeps the first events and the rest are dropped
        for (int i = 0; i < BURST_LEN; i++) begin
            send_frame(burst_codes[i], 1'b0);
            model[{1'b0, burst_codes[i]}] = 1'b1;
            expected_events++;
        end
        check_value("key_down", key_down, model);
        taken  = 0;
        waited = 0;
        while (taken < FIFO_DEPTH) begin
            if (waited >= DRAIN_TIMEOUT) begin
                stop_with_failure("Timed out draining the event FIFO");
            end
            rnd = $random(seed);
            key_event_ready = rnd[0];
            if (key_event_valid && key_event_ready) begin
                check_value("key_event_code", 512'(key_event_code),
                            512'({1'b0, burst_codes[taken]}));
                check_value("key_event_break", 512'(key_event_break), 512'(0));
                taken++;
            end
            settle(1);
            waited++;
        end
        key_event_ready = 1'b0;
        settle(2);
        check_value("key_event_valid", 512'(key_event_valid), 512'(0));
        expect_reg(REG_DROP_COUNT, "drop_count", 2);
        expect_reg(REG_EVENT_COUNT, "event_count", expected_events);

        // Writing a counter address clears that counter
        write_reg(REG_DROP_COUNT, 16'h0000);
        expect_reg(REG_DROP_COUNT, "drop_count", 0);
        write_reg(REG_ERR_COUNT, 16'h0000);
        expect_reg(REG_ERR_COUNT, "err_count", 0);

        // With enable low a make code changes nothing
        write_reg(REG_CTRL, 16'h0000);
        send_frame(8'h1B, 1'b0);
        expect_no_event();
        expect_reg(REG_EVENT_COUNT, "event_count", expected_events);
        write_reg(REG_CTRL, 16'h0001);

        write_reg(REG_CTRL, 16'h0005);
        settle(2);
        model = '0;
        check_value("key_down", key_down, model);
        expect_reg(REG_CTRL, "ctrl", 1);

        // skip_bat lets a fresh decoder work without the self-test byte
        apply_reset();
        expect_reg(REG_EVENT_COUNT, "event_count", 0);
        write_reg(REG_CTRL, 16'h0003);
        send_frame(8'h1C, 1'b0);
        take_event(9'h01C, 1'b0);
        model[9'h01C] = 1'b1;
        check_value("key_down", key_down, model);
        expect_reg(REG_EVENT_COUNT, "event_count", 1);

        $display("=== PASS ===");
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+testbench
src/ps2_pkg.sv
src/ps2_rx.sv
src/scan_decoder.sv
src/kbd_regs.sv
src/key_event_fifo.sv
src/kbd_top.sv
testbench/tb_kbd_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_kbd_top
BUILD_DIR ?= obj_dir
FILELIST  ?= all.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
SIM_ARGS  ?=

SOURCES := $(wildcard src/*.sv) $(wildcard testbench/*.sv) $(wildcard testbench/*.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) $(SIM_ARGS)

clean:
	rm -rf $(BUILD_DIR)
